// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert --timescale 1ns/10ps
TOP       ?= tb_mems_ctrl
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
+incdir+src
src/mems_pkg.sv
src/mirror_sequencer.sv
src/sweep_counter.sv
src/dac_word_builder.sv
src/spi_dac_master.sv
src/mems_ctrl_top.sv
test/tb_mems_ctrl.sv

// ==== src/dac_word_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mems_settings.svh"

module dac_word_builder
  import mems_pkg::*;
(
  input  frame_req_s frame_req,
  input  delta_set_s deltas,
  output dac_word_u  frame_word
);

  // address field value meaning every channel
  localparam logic [2:0] ADDR_ALL = 3'b111;

  logic [7:0] chan_delta;

  always_comb begin
    case (frame_req.chan)
      CH_A:    chan_delta = deltas.a;
      CH_B:    chan_delta = deltas.b;
      CH_C:    chan_delta = deltas.c;
      default: chan_delta = deltas.d;
    endcase
  end

  always_comb begin
    frame_word.raw = '0;
    case (frame_req.kind)
      FRAME_RESET: begin
        frame_word.ctrl.cmd  = `MEMS_CMD_RESET;
        frame_word.ctrl.addr = ADDR_ALL;
        frame_word.ctrl.cfg  = `MEMS_RESET_CONFIG;
      end
      FRAME_LDAC: begin
        frame_word.ctrl.cmd  = `MEMS_CMD_LDAC;
        frame_word.ctrl.addr = ADDR_ALL;
        frame_word.ctrl.cfg  = `MEMS_LDAC_CONFIG;
      end
      default: begin
        frame_word.wr.cmd  = `MEMS_CMD_WRITE_UPDATE;
        frame_word.wr.chan = {1'b0, frame_req.chan};
        // 8-bit delta in the top byte of the 16-bit code
        frame_word.wr.code = {chan_delta, 8'h00};
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/mems_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mems_ctrl_top
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  logic [7:0] cmd_byte,
  output logic       cmd_ready,
  output logic       sclk,
  output logic       mosi,
  output logic       sync_n
);

  logic       frame_valid;
  logic       frame_ready;
  frame_req_s frame_req;
  dac_word_u  frame_word;
  delta_set_s deltas;
  logic       step_a;
  logic       step_b;

  mirror_sequencer u_sequencer (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd_byte    (cmd_byte),
    .cmd_ready   (cmd_ready),
    .frame_valid (frame_valid),
    .frame_req   (frame_req),
    .frame_ready (frame_ready),
    .step_a      (step_a),
    .step_b      (step_b)
  );

  sweep_counter u_sweep (
    .clk    (clk),
    .rst    (rst),
    .step_a (step_a),
    .step_b (step_b),
    .deltas (deltas)
  );

  // word is formed combinationally from the pending request
  dac_word_builder u_builder (
    .frame_req  (frame_req),
    .deltas     (deltas),
    .frame_word (frame_word)
  );

  spi_dac_master u_spi (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame_word  (frame_word),
    .frame_ready (frame_ready),
    .sclk        (sclk),
    .mosi        (mosi),
    .sync_n      (sync_n)
  );

endmodule

`default_nettype wire

// ==== src/mems_pkg.sv ====
`default_nettype none

package mems_pkg;

  // control frame: reset and LDAC setup
  typedef struct packed {
    logic [1:0] pad;
    logic [2:0] cmd;
    logic [2:0] addr;
    logic [9:0] unused;
    logic [5:0] cfg;
  } dac_ctrl_s;

  // channel write frame
  typedef struct packed {
    logic [1:0]  pad;
    logic [2:0]  cmd;
    logic [2:0]  chan;
    logic [15:0] code;
  } dac_write_s;

  typedef union packed {
    dac_ctrl_s   ctrl;
    dac_write_s  wr;
    logic [23:0] raw;
  } dac_word_u;

  typedef enum logic [1:0] {FRAME_RESET, FRAME_LDAC, FRAME_WRITE} frame_kind_e;

  typedef enum logic [1:0] {CH_A, CH_B, CH_C, CH_D} channel_e;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_SOFT_RESET, SEQ_LDAC_SETUP, SEQ_SWEEP} seq_state_e;

  typedef struct packed {
    frame_kind_e kind;
    channel_e    chan;
  } frame_req_s;

  typedef struct packed {
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
  } delta_set_s;

endpackage

`default_nettype wire

// ==== src/mems_settings.svh ====
`ifndef MEMS_SETTINGS_SVH
`define MEMS_SETTINGS_SVH

// wrap bounds for the A/B pair
`define MEMS_UP_LIMIT     8'd161
`define MEMS_DOWN_LIMIT   8'd21

// wrap bounds for the C/D pair
`define MEMS_UP_LIMIT_2   8'd141
`define MEMS_DOWN_LIMIT_2 8'd41

// clk cycles per sclk half period
`define MEMS_SCLK_DIV     2

// DAC command codes
`define MEMS_CMD_WRITE_UPDATE 3'b011
`define MEMS_CMD_RESET        3'b101
`define MEMS_CMD_LDAC         3'b110

// full power-on reset
`define MEMS_RESET_CONFIG 6'b000001
// LDAC pin ignored on all four channels
`define MEMS_LDAC_CONFIG  6'b001111

`endif

// ==== src/mirror_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module mirror_sequencer
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  logic [7:0] cmd_byte,
  output logic       cmd_ready,
  output logic       frame_valid,
  output frame_req_s frame_req,
  input  logic       frame_ready,
  output logic       step_a,
  output logic       step_b
);

  // ASCII command bytes
  localparam logic [7:0] KEY_INIT = "h";
  localparam logic [7:0] KEY_PLAY = "p";
  localparam logic [7:0] KEY_STOP = "s";

  seq_state_e state_q;
  channel_e   ch_q;
  logic       cmd_fire;
  logic       frame_fire;

  // stall commands only while a request waits for the SPI master
  assign cmd_ready  = !(frame_valid && !frame_ready);
  assign cmd_fire   = cmd_valid && cmd_ready;
  assign frame_fire = frame_valid && frame_ready;

  // deltas move on the edge after the A/B word is taken
  assign step_a = frame_fire && (state_q == SEQ_SWEEP) && (ch_q == CH_A);
  assign step_b = frame_fire && (state_q == SEQ_SWEEP) && (ch_q == CH_B);

  // frame kind follows the state, channel follows the sub-state
  always_comb begin
    frame_req.chan = ch_q;
    case (state_q)
      SEQ_SOFT_RESET: frame_req.kind = FRAME_RESET;
      SEQ_LDAC_SETUP: frame_req.kind = FRAME_LDAC;
      default:        frame_req.kind = FRAME_WRITE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= SEQ_IDLE;
      ch_q        <= CH_A;
      frame_valid <= 1'b0;
    end else if (cmd_fire && cmd_byte == KEY_INIT) begin
      state_q     <= SEQ_SOFT_RESET;
      ch_q        <= CH_A;
      frame_valid <= 1'b1;
    end else if (cmd_fire && cmd_byte == KEY_PLAY) begin
      // straight into the sweep, no init frames
      state_q     <= SEQ_SWEEP;
      ch_q        <= CH_A;
      frame_valid <= 1'b1;
    end else if (cmd_fire && cmd_byte == KEY_STOP) begin
      // cmd_ready implies nothing is waiting, so nothing is lost here
      state_q     <= SEQ_IDLE;
      frame_valid <= 1'b0;
    end else if (frame_fire) begin
      case (state_q)
        SEQ_SOFT_RESET: begin
          state_q <= SEQ_LDAC_SETUP;
        end
        SEQ_LDAC_SETUP: begin
          state_q <= SEQ_SWEEP;
          ch_q    <= CH_A;
        end
        SEQ_SWEEP: begin
          // A, B, C, D and round again
          ch_q <= channel_e'(ch_q + 2'd1);
        end
        default: begin
          frame_valid <= 1'b0;
        end
      endcase
    end
  end

  // a waiting request must not change under back-pressure
  req_held: assert property (@(posedge clk) disable iff (rst)
    frame_valid && !frame_ready |=> frame_valid && $stable(frame_req))
    else $error("frame_req changed while waiting");

endmodule

`default_nettype wire

// ==== src/spi_dac_master.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mems_settings.svh"

module spi_dac_master
  import mems_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      frame_valid,
  input  dac_word_u frame_word,
  output logic      frame_ready,
  output logic      sclk,
  output logic      mosi,
  output logic      sync_n
);

  localparam int DIV = `MEMS_SCLK_DIV;
  localparam int DIV_W = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [4:0] LAST_BIT = 5'd23;

  logic             busy_q;
  logic [DIV_W-1:0] div_q;
  logic [4:0]       bit_cnt_q;
  logic [23:0]      shift_q;
  logic             load;
  logic             half_tick;

  assign frame_ready = !busy_q;
  assign load        = frame_valid && frame_ready;
  assign half_tick   = busy_q && !sync_n && (div_q == DIV_W'(DIV - 1));
  // msb first, new bit appears with each sclk rise
  assign mosi        = shift_q[23];

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q    <= 1'b0;
      sync_n    <= 1'b1;
      sclk      <= 1'b0;
      div_q     <= '0;
      bit_cnt_q <= '0;
    end else if (load) begin
      // first rise goes out together with the sync_n fall
      busy_q    <= 1'b1;
      sync_n    <= 1'b0;
      sclk      <= 1'b1;
      div_q     <= '0;
      bit_cnt_q <= '0;
    end else if (busy_q && sync_n) begin
      // one idle cycle after sync_n rises
      busy_q <= 1'b0;
    end else if (busy_q) begin
      if (half_tick) begin
        div_q <= '0;
        if (sclk) begin
          sclk <= 1'b0;
        end else if (bit_cnt_q == LAST_BIT) begin
          sync_n <= 1'b1;
        end else begin
          sclk      <= 1'b1;
          bit_cnt_q <= bit_cnt_q + 5'd1;
        end
      end else begin
        div_q <= div_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= frame_word.raw;
    end else if (half_tick && !sclk && bit_cnt_q != LAST_BIT) begin
      shift_q <= {shift_q[22:0], 1'b0};
    end
  end

  // no clock edges reach the DAC outside a frame
  sclk_in_frame: assert property (@(posedge clk) disable iff (rst)
    $changed(sclk) |-> !sync_n)
    else $error("sclk toggled with sync_n high");

endmodule

`default_nettype wire

// ==== src/sweep_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mems_settings.svh"

module sweep_counter
  import mems_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       step_a,
  input  logic       step_b,
  output delta_set_s deltas
);

  always_ff @(posedge clk) begin
    if (rst) begin
      deltas.a <= `MEMS_DOWN_LIMIT;
      deltas.b <= `MEMS_UP_LIMIT;
      deltas.c <= `MEMS_DOWN_LIMIT_2;
      deltas.d <= `MEMS_UP_LIMIT_2;
    end else if (step_a) begin
      if (deltas.a > `MEMS_UP_LIMIT) begin
        // A/B sweep wraps
        deltas.a <= `MEMS_DOWN_LIMIT;
        deltas.b <= `MEMS_UP_LIMIT;
        // C/D only move once per A/B wrap
        if (deltas.c > `MEMS_UP_LIMIT_2) begin
          deltas.c <= `MEMS_DOWN_LIMIT_2;
          deltas.d <= `MEMS_UP_LIMIT_2;
        end else begin
          deltas.c <= deltas.c + 8'd1;
          deltas.d <= deltas.d - 8'd1;
        end
      end else begin
        deltas.a <= deltas.a + 8'd1;
      end
    end else if (step_b) begin
      deltas.b <= deltas.b - 8'd1;
    end
  end

  // A overshoots UP by one before it wraps
  a_in_range: assert property (@(posedge clk) disable iff (rst)
    (deltas.a >= `MEMS_DOWN_LIMIT) && (deltas.a <= `MEMS_UP_LIMIT + 8'd1))
    else $error("delta A out of range: %0d", deltas.a);

endmodule

`default_nettype wire

// ==== test/tb_mems_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mems_settings.svh"

module tb_mems_ctrl;

  localparam int SWEEP_ROUNDS  = 120;
  localparam int RESUME_ROUNDS = 35;
  localparam int FRAME_CYCLES  = 100;
  // init pair and first sweep, plus the word in flight at stop and the resumed sweep
  localparam int TOTAL_FRAMES  = 2 + 4 * SWEEP_ROUNDS + 1 + 4 * RESUME_ROUNDS;
  localparam int CYCLE_LIMIT   = TOTAL_FRAMES * FRAME_CYCLES + 5000;

  logic        clk;
  logic        rst;
  logic        cmd_valid;
  logic [7:0]  cmd_byte;
  logic        cmd_ready;
  logic        sclk;
  logic        mosi;
  logic        sync_n;

  int          seed;
  int          cycles;
  // frame monitor
  logic        sclk_prev;
  int          mon_bits;
  logic [23:0] shift_in;
  logic [23:0] got_word;
  logic [23:0] exp_word;
  logic        word_done;
  int          words_seen;
  // model slot 0 is reset, 1 is LDAC and 2 to 5 are channels A to D
  int          slot;
  logic [7:0]  m_a;
  logic [7:0]  m_b;
  logic [7:0]  m_c;
  logic [7:0]  m_d;
  // phase flags
  logic        quiet;
  logic        stopped;
  int          stop_base;

  mems_ctrl_top dut (
    .clk       (clk),
    .rst       (rst),
    .cmd_valid (cmd_valid),
    .cmd_byte  (cmd_byte),
    .cmd_ready (cmd_ready),
    .sclk      (sclk),
    .mosi      (mosi),
    .sync_n    (sync_n)
  );

  always #2 clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      fail_run($sformatf("timeout after %0d cycles, %0d words seen", cycles, words_seen));
    end
  end

  task automatic step_model_a();
    if (m_a > `MEMS_UP_LIMIT) begin
      m_a = `MEMS_DOWN_LIMIT;
      m_b = `MEMS_UP_LIMIT;
      if (m_c > `MEMS_UP_LIMIT_2) begin
        m_c = `MEMS_DOWN_LIMIT_2;
        m_d = `MEMS_UP_LIMIT_2;
      end else begin
        m_c = m_c + 8'd1;
        m_d = m_d - 8'd1;
      end
    end else begin
      m_a = m_a + 8'd1;
    end
  endtask

  // model moves on after each predicted word as the DUT does
  task automatic predict_word(output logic [23:0] w);
    logic [7:0] code_hi;
    case (slot)
      2:       code_hi = m_a;
      3:       code_hi = m_b;
      4:       code_hi = m_c;
      default: code_hi = m_d;
    endcase
    if (slot == 0) begin
      w = {2'b00, `MEMS_CMD_RESET, 3'b111, 10'd0, `MEMS_RESET_CONFIG};
    end else if (slot == 1) begin
      w = {2'b00, `MEMS_CMD_LDAC, 3'b111, 10'd0, `MEMS_LDAC_CONFIG};
    end else begin
      w = {2'b00, `MEMS_CMD_WRITE_UPDATE, 1'b0, 2'(slot - 2), code_hi, 8'h00};
    end
    if (slot == 2) begin
      step_model_a();
    end else if (slot == 3) begin
      m_b = m_b - 8'd1;
    end
    slot = (slot == 5) ? 2 : slot + 1;
  endtask

  // bits taken on each sclk fall inside a frame
  always @(negedge clk) begin
    word_done = 1'b0;
    if (rst) begin
      mon_bits = 0;
    end else if (sclk_prev && !sclk && !sync_n) begin
      shift_in = {shift_in[22:0], mosi};
      mon_bits = mon_bits + 1;
      if (mon_bits == 24) begin
        mon_bits   = 0;
        got_word   = shift_in;
        predict_word(exp_word);
        words_seen = words_seen + 1;
        word_done  = 1'b1;
      end
    end
    sclk_prev = sclk;
  end

  word_match: assert property (@(posedge clk) disable iff (rst)
    word_done |-> got_word == exp_word)
    else fail_run($sformatf("Mismatch mosi word: got %06h expected %06h",
                            got_word, exp_word));

  idle_quiet: assert property (@(posedge clk) disable iff (rst)
    quiet |-> sync_n && !sclk && cmd_ready)
    else fail_run("SPI activity or cmd_ready low while the controller should be idle");

  frame_length: assert property (@(posedge clk) disable iff (rst)
    $rose(sync_n) |-> mon_bits == 0)
    else fail_run($sformatf("frame ended after a partial word of %0d bits", mon_bits));

  stop_limit: assert property (@(posedge clk) disable iff (rst)
    stopped |-> words_seen - stop_base <= 1)
    else fail_run("more than one word went out after the stop command");

  task automatic send_cmd(input logic [7:0] b);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_byte  = b;
    // ready is stable here and the byte goes on the next rising edge
    while (!cmd_ready) @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic idle_gap(input int max_cycles);
    int n;
    n = $unsigned($random(seed)) % max_cycles;
    repeat (n + 1) @(negedge clk);
  endtask

  task automatic wait_words(input int count);
    while (words_seen < count) @(negedge clk);
  endtask

  // bytes that carry no command
  function automatic logic [7:0] ignored_byte(input logic [1:0] pick);
    case (pick)
      2'd0:    return "x";
      2'd1:    return "q";
      2'd2:    return "H";
      default: return 8'h00;
    endcase
  endfunction

  initial begin
    seed       = 32'hb55a5d30;
    clk        = 1'b0;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_byte   = 8'h00;
    cycles     = 0;
    sclk_prev  = 1'b0;
    mon_bits   = 0;
    shift_in   = '0;
    got_word   = '0;
    exp_word   = '0;
    word_done  = 1'b0;
    words_seen = 0;
    slot       = 0;
    m_a        = `MEMS_DOWN_LIMIT;
    m_b        = `MEMS_UP_LIMIT;
    m_c        = `MEMS_DOWN_LIMIT_2;
    m_d        = `MEMS_UP_LIMIT_2;
    quiet      = 1'b0;
    stopped    = 1'b0;
    stop_base  = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // stray bytes start nothing while idle
    quiet = 1'b1;
    repeat (6) begin
      idle_gap(32);
      send_cmd(ignored_byte(2'($random(seed))));
    end
    repeat (200) @(negedge clk);
    quiet = 1'b0;

    // init pair then the sweep with stray bytes mixed in
    send_cmd("h");
    while (words_seen < 2 + 4 * SWEEP_ROUNDS - 8) begin
      idle_gap(64);
      send_cmd(ignored_byte(2'($random(seed))));
    end
    wait_words(2 + 4 * SWEEP_ROUNDS);

    // the word handed over with the stop still completes
    send_cmd("s");
    stop_base = words_seen;
    stopped   = 1'b1;
    while (!sync_n) @(negedge clk);
    repeat (4) @(negedge clk);
    quiet = 1'b1;
    repeat (3) begin
      idle_gap(64);
      send_cmd(ignored_byte(2'($random(seed))));
    end
    repeat (300) @(negedge clk);
    quiet   = 1'b0;
    stopped = 1'b0;

    // resume at channel A with the deltas kept
    slot = 2;
    send_cmd("p");
    wait_words(words_seen + 4 * RESUME_ROUNDS);
    @(negedge clk);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
